// ==== lar_wb.f ====
logic/lar_pkg.sv
logic/credit_fifo.sv
logic/wb_stage.sv
logic/lar_file.sv
logic/lar_wb_top.sv
tb/lar_wb_props.sv
tb/lar_wb_tb.sv

// ==== logic/credit_fifo.sv ====
`timescale 1ns/10ps

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t head,
	output logic not_empty,
	output logic credit_return,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t slots [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + PTR_W'(1);
	endfunction

	assign empty = (count == '0);
	assign not_empty = !empty;
	assign head = slots[rd_ptr];
	assign credit_return = pop; // slot is free again in this cycle

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
			2'b10: count <= count + CNT_W'(1);
			2'b01: count <= count - CNT_W'(1);
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wr_ptr] <= push_data; // sender never overruns its credits
	end

endmodule

// ==== logic/lar_file.sv ====
`timescale 1ns/10ps

module lar_file #(
	parameter int REQ_CREDITS = 2,
	parameter int MEM_LATENCY = 3,
	parameter int NUM_LARS = lar_pkg::NUM_LARS,
	parameter int MEM_WORDS = lar_pkg::MEM_WORDS
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input lar_pkg::lar_wr_req_t req,
	output logic req_credit,
	output logic wr_done,
	input logic [$clog2(NUM_LARS)-1:0] rd_index,
	output lar_pkg::lar_entry_t rd_entry
);

	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	typedef enum logic
	{
		SEQ_IDLE,
		SEQ_BUSY
	} seq_e;

	lar_pkg::lar_entry_t lars [NUM_LARS];
	logic [lar_pkg::DATA_W-1:0] mem [MEM_WORDS];
	lar_pkg::lar_wr_req_t cur;
	logic q_empty;
	logic start;
	seq_e seq_q;
	logic [LAT_W-1:0] lat_q;
	logic [lar_pkg::DATA_W-1:0] mem_word;
	logic [lar_pkg::DATA_W-1:0] size_mask;
	logic [lar_pkg::DATA_W-1:0] store_word;
	logic [lar_pkg::DATA_W-1:0] load_data;

	// slot is held until its request completes
	credit_fifo #(
		.payload_t(lar_pkg::lar_wr_req_t),
		.DEPTH(REQ_CREDITS)
	) u_req_q (
		.clk(clk),
		.rst_n(rst_n),
		.push(req_valid),
		.push_data(req),
		.pop(wr_done),
		.head(cur),
		.not_empty(),
		.credit_return(req_credit),
		.empty(q_empty)
	);

	assign rd_entry = lars[rd_index];

	//////////////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////////////

	assign start = (seq_q == SEQ_IDLE) && !q_empty;
	assign wr_done = (seq_q == SEQ_BUSY) && (lat_q == '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seq_q <= SEQ_IDLE;
			lat_q <= '0;
		end
		else
		begin
			case (seq_q)
			SEQ_IDLE:
			begin
				if (start)
				begin
					seq_q <= SEQ_BUSY;
					lat_q <= (cur.write_typ == lar_pkg::WR_TYP_ONLY_DATA)
						? '0 : LAT_W'(MEM_LATENCY - 1);
				end
			end
			SEQ_BUSY:
			begin
				if (lat_q == '0)
					seq_q <= SEQ_IDLE;
				else
					lat_q <= lat_q - LAT_W'(1);
			end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// data path
	//////////////////////////////////////////////////////////////////////

	assign mem_word = mem[cur.ldst_addr];

	always_comb
	begin
		case (cur.int_size)
		lar_pkg::INT_SZ_8: size_mask = 64'h0000_0000_0000_00ff;
		lar_pkg::INT_SZ_16: size_mask = 64'h0000_0000_0000_ffff;
		lar_pkg::INT_SZ_32: size_mask = 64'h0000_0000_ffff_ffff;
		default: size_mask = '1;
		endcase
	end

	// upper bits of the memory word survive a narrow store
	assign store_word = (mem_word & ~size_mask) | (lars[cur.index].data & size_mask);

	always_comb
	begin
		load_data = mem_word & size_mask; // unsigned and bfloat16
		if (cur.data_typ == lar_pkg::DATA_TYP_SGN_INT)
		begin
			case (cur.int_size)
			lar_pkg::INT_SZ_8: load_data = {{56{mem_word[7]}}, mem_word[7:0]};
			lar_pkg::INT_SZ_16: load_data = {{48{mem_word[15]}}, mem_word[15:0]};
			lar_pkg::INT_SZ_32: load_data = {{32{mem_word[31]}}, mem_word[31:0]};
			default: load_data = mem_word;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_LARS; i++)
				lars[i] <= '0;
		end
		else if (start && (cur.write_typ != lar_pkg::WR_TYP_ONLY_DATA))
		begin
			lars[cur.index].addr <= cur.ldst_addr; // address and type go in first
			lars[cur.index].data_typ <= cur.data_typ;
			lars[cur.index].int_size <= cur.int_size;
		end
		else if (wr_done)
		begin
			case (cur.write_typ)
			lar_pkg::WR_TYP_ONLY_DATA: lars[cur.index].data <= cur.non_ldst_data;
			lar_pkg::WR_TYP_LOAD: lars[cur.index].data <= load_data;
			default: ; // store leaves the LAR data alone
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (wr_done && (cur.write_typ == lar_pkg::WR_TYP_STORE))
		begin
			mem[cur.ldst_addr] <= store_word;
		end
	end

endmodule

// ==== logic/lar_pkg.sv ====
package lar_pkg;

	//////////////////////////////////////////////////////////////////////
	// default sizes
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_LARS = 16;
	localparam int MEM_WORDS = 64;
	localparam int DATA_W = 64;
	localparam int LAR_IDX_W = $clog2(NUM_LARS);
	localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		DATA_TYP_UNSGN_INT,
		DATA_TYP_SGN_INT,
		DATA_TYP_BFLOAT16
	} data_typ_e;

	typedef enum logic [1:0]
	{
		INT_SZ_8,
		INT_SZ_16,
		INT_SZ_32,
		INT_SZ_64
	} int_size_e;

	typedef enum logic [1:0]
	{
		GRP_ALU,
		GRP_LOAD,
		GRP_STORE,
		GRP_NONE
	} instr_group_e;

	typedef enum logic [1:0]
	{
		WR_TYP_ONLY_DATA,
		WR_TYP_LOAD,
		WR_TYP_STORE
	} write_typ_e;

	//////////////////////////////////////////////////////////////////////
	// payloads
	//////////////////////////////////////////////////////////////////////

	typedef struct packed
	{
		instr_group_e group;
		logic [LAR_IDX_W-1:0] ra_index;
		data_typ_e data_typ;              // loads and stores only
		int_size_e int_size;              // bfloat16 means 16
		logic [MEM_ADDR_W-1:0] ldst_addr;
		logic [DATA_W-1:0] computed_data;
	} exec_instr_t;

	typedef struct packed
	{
		write_typ_e write_typ;
		logic [LAR_IDX_W-1:0] index;
		data_typ_e data_typ;
		int_size_e int_size;
		logic [MEM_ADDR_W-1:0] ldst_addr;
		logic [DATA_W-1:0] non_ldst_data;
	} lar_wr_req_t;

	typedef struct packed
	{
		logic [DATA_W-1:0] data;
		logic [MEM_ADDR_W-1:0] addr;     // word address
		data_typ_e data_typ;
		int_size_e int_size;
	} lar_entry_t;

endpackage

// ==== logic/lar_wb_top.sv ====
`timescale 1ns/10ps

module lar_wb_top #(
	parameter int INSTR_CREDITS = 4,
	parameter int REQ_CREDITS = 2,
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lar_pkg::exec_instr_t instr,
	output logic instr_credit,
	input logic [lar_pkg::LAR_IDX_W-1:0] rd_index,
	output lar_pkg::lar_entry_t rd_entry,
	output logic idle
);

	logic req_valid;
	lar_pkg::lar_wr_req_t req;
	logic req_credit;
	logic wr_done;

	wb_stage #(
		.INSTR_CREDITS(INSTR_CREDITS),
		.REQ_CREDITS(REQ_CREDITS)
	) u_wb (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_credit(instr_credit),
		.req_valid(req_valid),
		.req(req),
		.req_credit(req_credit),
		.wr_done(wr_done),
		.idle(idle)
	);

	lar_file #(
		.REQ_CREDITS(REQ_CREDITS),
		.MEM_LATENCY(MEM_LATENCY),
		.NUM_LARS(lar_pkg::NUM_LARS),
		.MEM_WORDS(lar_pkg::MEM_WORDS)
	) u_lar (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req(req),
		.req_credit(req_credit),
		.wr_done(wr_done),
		.rd_index(rd_index),
		.rd_entry(rd_entry)
	);

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/10ps

module wb_stage #(
	parameter int INSTR_CREDITS = 4,
	parameter int REQ_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input lar_pkg::exec_instr_t instr,
	output logic instr_credit,
	output logic req_valid,
	output lar_pkg::lar_wr_req_t req,
	input logic req_credit,
	input logic wr_done,
	output logic idle
);

	localparam int CNT_W = $clog2(REQ_CREDITS + 1);

	typedef enum logic
	{
		ST_REGULAR,
		ST_WAIT_LAR
	} state_e;

	state_e state_q;
	state_e state_d;
	lar_pkg::exec_instr_t cur;
	logic q_not_empty;
	logic q_empty;
	logic pop;
	logic is_ldst;
	logic [CNT_W-1:0] req_cnt_q;

	credit_fifo #(
		.payload_t(lar_pkg::exec_instr_t),
		.DEPTH(INSTR_CREDITS)
	) u_instr_q (
		.clk(clk),
		.rst_n(rst_n),
		.push(instr_valid),
		.push_data(instr),
		.pop(pop),
		.head(cur),
		.not_empty(q_not_empty),
		.credit_return(instr_credit),
		.empty(q_empty)
	);

	//////////////////////////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////////////////////////

	assign is_ldst = (cur.group == lar_pkg::GRP_LOAD) || (cur.group == lar_pkg::GRP_STORE);

	// a dropped instruction needs no LAR file credit
	assign pop = (state_q == ST_REGULAR) && q_not_empty
		&& ((req_cnt_q != '0) || (cur.group == lar_pkg::GRP_NONE));
	assign req_valid = pop && (cur.group != lar_pkg::GRP_NONE);

	always_comb
	begin
		req = '0;
		req.index = cur.ra_index;
		req.ldst_addr = cur.ldst_addr;
		req.non_ldst_data = cur.computed_data;
		case (cur.group)
		lar_pkg::GRP_LOAD:
		begin
			req.write_typ = lar_pkg::WR_TYP_LOAD;
			req.data_typ = cur.data_typ;
			req.int_size = cur.int_size;
		end
		lar_pkg::GRP_STORE:
		begin
			req.write_typ = lar_pkg::WR_TYP_STORE;
			req.data_typ = cur.data_typ;
			req.int_size = cur.int_size;
		end
		default: req.write_typ = lar_pkg::WR_TYP_ONLY_DATA;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
		ST_REGULAR:
		begin
			if (req_valid && is_ldst)
				state_d = ST_WAIT_LAR;
		end
		ST_WAIT_LAR:
		begin
			// in-order completion: the last outstanding request is the load/store
			if (wr_done && (req_cnt_q == CNT_W'(REQ_CREDITS - 1)))
				state_d = ST_REGULAR;
		end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= ST_REGULAR;
			req_cnt_q <= CNT_W'(REQ_CREDITS);
		end
		else
		begin
			state_q <= state_d;
			case ({req_valid, req_credit})
			2'b10: req_cnt_q <= req_cnt_q - CNT_W'(1);
			2'b01: req_cnt_q <= req_cnt_q + CNT_W'(1);
			default: ;
			endcase
		end
	end

	// full credits means the LAR file has drained
	assign idle = q_empty && (state_q == ST_REGULAR) && (req_cnt_q == CNT_W'(REQ_CREDITS));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lar_wb.f --top-module lar_wb_tb \
	-o lar_wb_sim --Mdir obj_dir || { echo "build failed"; exit 1; }

out=$(./obj_dir/lar_wb_sim)
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb/lar_wb_props.sv ====
`timescale 1ns/10ps

module lar_wb_props (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_credit_zero,
	input logic wr_done,
	input logic lar_q_empty,
	input logic wb_waiting,
	input logic idle
);

	//////////////////////////////////////////////////////////////////////
	// credit and completion rules
	//////////////////////////////////////////////////////////////////////

	req_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !req_credit_zero)
		else $error("request issued while the stage holds no LAR file credit");

	done_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		wr_done |-> !lar_q_empty)
		else $error("write completion with an empty LAR file queue");

	// neither a waiting stage nor a LAR file with work is idle
	no_idle_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_waiting || !lar_q_empty) |-> !idle)
		else $error("idle raised while the stage waits or the LAR file holds work");

endmodule

// ==== tb/lar_wb_tb.sv ====
`timescale 1ns/10ps

module lar_wb_tb;

	localparam int INSTR_CREDITS = 4;
	localparam int REQ_CREDITS = 2;
	localparam int MEM_LATENCY = 3;
	localparam int IDX_W = lar_pkg::LAR_IDX_W;
	localparam int ADDR_W = lar_pkg::MEM_ADDR_W;
	localparam int ALU_COUNT = 40;
	localparam int STORE_COUNT = 24;
	localparam int LOAD_COUNT = 36;
	localparam int BURST_COUNT = 48;
	localparam int MIX_COUNT = 300;
	localparam int NUM_INSTR = ALU_COUNT + STORE_COUNT + LOAD_COUNT + BURST_COUNT + MIX_COUNT;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * (MEM_LATENCY + 4) + 1000;

	logic clk;
	logic rst_n;
	logic instr_valid;
	lar_pkg::exec_instr_t instr;
	logic instr_credit;
	logic [IDX_W-1:0] rd_index;
	lar_pkg::lar_entry_t rd_entry;
	logic idle;

	lar_pkg::lar_entry_t model_lars [lar_pkg::NUM_LARS];
	logic [lar_pkg::DATA_W-1:0] model_mem [lar_pkg::MEM_WORDS];
	int seed;
	int credits;
	bit over_credit;
	int cycle_cnt = 0;
	int errors;
	int checks;
	int tests_run;
	int test_err_start;

	lar_wb_top #(
		.INSTR_CREDITS(INSTR_CREDITS),
		.REQ_CREDITS(REQ_CREDITS),
		.MEM_LATENCY(MEM_LATENCY)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_credit(instr_credit),
		.rd_index(rd_index),
		.rd_entry(rd_entry),
		.idle(idle)
	);

	bind lar_wb_top lar_wb_props u_props (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_credit_zero(u_lar.u_req_q.count == REQ_CREDITS), // full queue leaves no credit
		.wr_done(wr_done),
		.lar_q_empty(u_lar.q_empty),
		.wb_waiting(u_wb.state_q), // 1 in the wait state
		.idle(idle)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	function automatic string format_entry(input lar_pkg::lar_entry_t e);
		return $sformatf("data=%h addr=%0d typ=%0d size=%0d",
			e.data, e.addr, e.data_typ, e.int_size);
	endfunction

	task automatic compare_entry(input string name, input lar_pkg::lar_entry_t exp,
		input lar_pkg::lar_entry_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s: expected %s, actual %s", name,
				format_entry(exp), format_entry(act));
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic start_test();
		test_err_start = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	task automatic apply_model(input lar_pkg::exec_instr_t ins);
		int bits;
		logic [63:0] mask;
		logic [63:0] word;
		bits = (ins.data_typ == lar_pkg::DATA_TYP_BFLOAT16) ? 16 : (8 << ins.int_size);
		mask = {64{1'b1}} >> (64 - bits);
		word = model_mem[ins.ldst_addr];
		if (ins.group == lar_pkg::GRP_LOAD || ins.group == lar_pkg::GRP_STORE)
		begin
			model_lars[ins.ra_index].addr = ins.ldst_addr;
			model_lars[ins.ra_index].data_typ = ins.data_typ;
			model_lars[ins.ra_index].int_size = ins.int_size;
		end
		case (ins.group)
		lar_pkg::GRP_ALU: model_lars[ins.ra_index].data = ins.computed_data;
		lar_pkg::GRP_LOAD:
		begin
			model_lars[ins.ra_index].data = word & mask;
			if (ins.data_typ == lar_pkg::DATA_TYP_SGN_INT && word[bits-1])
				model_lars[ins.ra_index].data = word | ~mask; // sign fill
		end
		lar_pkg::GRP_STORE:
			model_mem[ins.ldst_addr] = (word & ~mask) | (model_lars[ins.ra_index].data & mask);
		default: ;
		endcase
	endtask

	task automatic make_instr(input lar_pkg::instr_group_e grp, input int unsigned span,
		output lar_pkg::exec_instr_t ins);
		int unsigned r;
		ins = '0;
		ins.group = grp;
		r = $random(seed);
		ins.ra_index = IDX_W'(r % lar_pkg::NUM_LARS);
		ins.computed_data = {$random(seed), $random(seed)};
		r = $random(seed);
		ins.ldst_addr = ADDR_W'(r % span);
		r = $random(seed);
		ins.data_typ = lar_pkg::data_typ_e'(2'(r % 3));
		ins.int_size = lar_pkg::int_size_e'(r[9:8]);
		if (ins.data_typ == lar_pkg::DATA_TYP_BFLOAT16)
			ins.int_size = lar_pkg::INT_SZ_16;
	endtask

	// k 0..3 signed, 4..7 unsigned, 8 bfloat16
	function automatic lar_pkg::exec_instr_t with_type(input lar_pkg::exec_instr_t ins,
		input int k);
		lar_pkg::exec_instr_t t;
		t = ins;
		t.data_typ = (k < 4) ? lar_pkg::DATA_TYP_SGN_INT
			: (k < 8) ? lar_pkg::DATA_TYP_UNSGN_INT : lar_pkg::DATA_TYP_BFLOAT16;
		t.int_size = (k < 8) ? lar_pkg::int_size_e'(2'(k % 4)) : lar_pkg::INT_SZ_16;
		return t;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// driving
	//////////////////////////////////////////////////////////////////////

	task automatic clock_cycle(input bit want, input lar_pkg::exec_instr_t ins, output bit sent);
		bit returned;
		@(negedge clk);
		returned = instr_credit; // pop happens at the coming rising edge
		sent = want && (credits > 0);
		instr_valid = sent;
		instr = ins;
		if (sent)
			credits--;
		if (returned)
			credits++;
		if (credits > INSTR_CREDITS)
			over_credit = 1'b1;
	endtask

	task automatic idle_cycle();
		bit dropped;
		clock_cycle(1'b0, '0, dropped);
	endtask

	task automatic send_instr(input lar_pkg::exec_instr_t ins);
		bit sent;
		sent = 1'b0;
		while (!sent)
			clock_cycle(1'b1, ins, sent);
		apply_model(ins);
	endtask

	task automatic wait_idle();
		idle_cycle();
		while (!idle)
			idle_cycle();
	endtask

	task automatic check_lars(input string test);
		for (int i = 0; i < lar_pkg::NUM_LARS; i++)
		begin
			rd_index = IDX_W'(i);
			idle_cycle();
			compare_entry($sformatf("%s lar%0d", test, i), model_lars[i], rd_entry);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		lar_pkg::exec_instr_t ins;
		int unsigned r;
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		rd_index = '0;
		seed = 48;
		credits = 0;
		over_credit = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		for (int i = 0; i < lar_pkg::NUM_LARS; i++)
			model_lars[i] = '0;
		for (int i = 0; i < lar_pkg::MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		credits = INSTR_CREDITS;

		start_test();
		idle_cycle();
		compare_bit("reset_state idle", 1'b1, idle);
		check_lars("reset_state");
		finish_test("reset_state");

		start_test();
		for (int i = 0; i < ALU_COUNT; i++)
		begin
			make_instr(lar_pkg::GRP_ALU, 64, ins);
			send_instr(ins);
		end
		wait_idle();
		check_lars("alu_writes");
		finish_test("alu_writes");

		start_test();
		for (int i = 0; i < STORE_COUNT; i++)
		begin
			make_instr(lar_pkg::GRP_STORE, 8, ins);
			send_instr(ins);
		end
		for (int i = 0; i < LOAD_COUNT; i++)
		begin
			make_instr(lar_pkg::GRP_LOAD, 8, ins);
			send_instr(with_type(ins, i % 9));
		end
		wait_idle();
		check_lars("store_then_load");
		finish_test("store_then_load");

		start_test();
		for (int i = 0; i < BURST_COUNT; i++)
		begin
			r = $random(seed);
			make_instr(r[0] ? lar_pkg::GRP_LOAD : lar_pkg::GRP_ALU, 64, ins);
			send_instr(ins);
		end
		wait_idle();
		compare_bit("credit_limit all credits back", 1'b1, credits == INSTR_CREDITS);
		compare_bit("credit_limit no excess credit", 1'b0, over_credit);
		check_lars("credit_limit");
		finish_test("credit_limit");

		start_test();
		for (int i = 0; i < MIX_COUNT; i++)
		begin
			r = $random(seed);
			make_instr(lar_pkg::instr_group_e'(2'(r % 4)), 16, ins);
			send_instr(ins);
			r = $random(seed);
			repeat (r % 4) idle_cycle();
		end
		wait_idle();
		check_lars("random_mix");
		finish_test("random_mix");

		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
